/* verilog.f */
+incdir+verification
verilog/soc_bus_pkg.sv
verilog/word_ram.sv
verilog/plic.sv
verilog/bus_sequencer.sv
verilog/soc_bus_top.sv
verification/tb_soc_bus.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_soc_bus
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verification/tb_soc_bus_tasks.svh */
`ifndef TB_SOC_BUS_TASKS_SVH
`define TB_SOC_BUS_TASKS_SVH

// report the reason and end the run
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", why);
endtask

task automatic check_dword(input string name, input soc_bus_pkg::dword_t got,
                           input soc_bus_pkg::dword_t exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

// one edge plus the drive delay
task automatic next_cycle();
    @(posedge CLOCK_50);
    #drive_delay;
endtask

task automatic bus_write(input soc_bus_pkg::dword_t addr, input soc_bus_pkg::ls_type_t t,
                         input soc_bus_pkg::dword_t data);
    address    = addr;
    write_data = data;
    ls_type    = t;
    write_en   = 1'b1;
    next_cycle();
    write_en = 1'b0;
    if (write_done) abort_run("write_done did not fall after a write enable");
    // bus lines stay put until done is back
    while (!write_done) next_cycle();
endtask

task automatic bus_read(input soc_bus_pkg::dword_t addr, input soc_bus_pkg::ls_type_t t,
                        output soc_bus_pkg::dword_t data);
    address = addr;
    ls_type = t;
    read_en = 1'b1;
    next_cycle();
    read_en = 1'b0;
    if (read_done) abort_run("read_done did not fall after a read enable");
    while (!read_done) next_cycle();
    data = read_data;
endtask

task automatic read_check(input string name, input soc_bus_pkg::dword_t addr,
                          input soc_bus_pkg::ls_type_t t, input soc_bus_pkg::dword_t exp);
    soc_bus_pkg::dword_t data;
    bus_read(addr, t, data);
    check_dword(name, data, exp);
endtask

task automatic test_reset_state();
    check_bit("read_done", read_done, 1'b1);
    check_bit("write_done", write_done, 1'b1);
    check_bit("meip", meip, 1'b0);
    check_bit("seip", seip, 1'b0);
    check_bit("mtip", mtip, 1'b0);
    read_check("mtimecmp", soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, 64'h8000_0000);
endtask

task automatic test_ram_word();
    soc_bus_pkg::word_t  w;
    soc_bus_pkg::dword_t d;
    // bit 31 forced so lw and lwu differ
    w = $urandom() | 32'h8000_0000;
    d = {$urandom(), $urandom()};
    bus_write(64'h8000_0010, soc_bus_pkg::ls_w, {32'h0, w});
    read_check("lw", 64'h8000_0010, soc_bus_pkg::ls_w, {32'hffff_ffff, w});
    read_check("lwu", 64'h8000_0010, soc_bus_pkg::ls_wu, {32'h0, w});
    bus_write(64'h8000_0020, soc_bus_pkg::ls_d, d);
    read_check("ld", 64'h8000_0020, soc_bus_pkg::ls_d, d);
    // low half sits at the lower word index
    read_check("lw low", 64'h8000_0020, soc_bus_pkg::ls_w, {{32{d[31]}}, d[31:0]});
    read_check("lw high", 64'h8000_0024, soc_bus_pkg::ls_w, {{32{d[63]}}, d[63:32]});
endtask

task automatic test_ram_bytes();
    soc_bus_pkg::word_t exp;
    logic [7:0]         b;
    int                 k;
    exp = '0;
    bus_write(64'h8000_0040, soc_bus_pkg::ls_w, 64'h0);
    for (k = 0; k < 4; k++) begin
        b = 8'($urandom());
        exp[8*k +: 8] = b;
        // noise above the byte must not land
        bus_write(64'h8000_0040 + soc_bus_pkg::dword_t'(k), soc_bus_pkg::ls_b,
                  {$urandom(), 24'($urandom()), b});
        read_check("lw after sb", 64'h8000_0040, soc_bus_pkg::ls_w, {{32{exp[31]}}, exp});
    end
    bus_write(64'h8000_0050, soc_bus_pkg::ls_w, 64'h80f1_7f85);
    read_check("lb", 64'h8000_0050, soc_bus_pkg::ls_b, 64'hffff_ffff_ffff_ff85);
    read_check("lbu", 64'h8000_0050, soc_bus_pkg::ls_bu, 64'h85);
    read_check("lb off 1", 64'h8000_0051, soc_bus_pkg::ls_b, 64'h7f);
    read_check("lb off 3", 64'h8000_0053, soc_bus_pkg::ls_b, 64'hffff_ffff_ffff_ff80);
    read_check("lh", 64'h8000_0050, soc_bus_pkg::ls_h, 64'h7f85);
    read_check("lh off 2", 64'h8000_0052, soc_bus_pkg::ls_h, 64'hffff_ffff_ffff_80f1);
    read_check("lhu off 2", 64'h8000_0052, soc_bus_pkg::ls_hu, 64'h80f1);
    // upper half only
    bus_write(64'h8000_0052, soc_bus_pkg::ls_h, 64'hdead_1234);
    read_check("lwu after sh", 64'h8000_0050, soc_bus_pkg::ls_wu, 64'h1234_7f85);
endtask

task automatic test_timer();
    mtime = mtime_value;
    read_check("mtime", soc_bus_pkg::mtime_addr, soc_bus_pkg::ls_d, mtime_value);
    // reset compare sits below the driven time, so mtip starts high
    bus_write(soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, mtime_value + 64'd5);
    check_bit("mtip", mtip, 1'b0);
    bus_write(soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, mtime_value - 64'd5);
    check_bit("mtip", mtip, 1'b1);
    read_check("mtimecmp", soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, mtime_value - 64'd5);
endtask

task automatic test_plic_regs();
    soc_bus_pkg::dword_t pb;
    pb = soc_bus_pkg::plic_base;
    // priority keeps 3 bits
    bus_write(pb + 64'h8, soc_bus_pkg::ls_w, 64'h1f);
    read_check("priority 2", pb + 64'h8, soc_bus_pkg::ls_w, 64'h7);
    bus_write(pb + 64'h4, soc_bus_pkg::ls_w, 64'h5);
    read_check("priority 1", pb + 64'h4, soc_bus_pkg::ls_w, 64'h5);
    bus_write(pb + 64'h20_0000, soc_bus_pkg::ls_w, 64'hd);
    read_check("threshold 0", pb + 64'h20_0000, soc_bus_pkg::ls_w, 64'h5);
    bus_write(pb + 64'h20_1000, soc_bus_pkg::ls_w, 64'h3);
    read_check("threshold 1", pb + 64'h20_1000, soc_bus_pkg::ls_w, 64'h3);
    bus_write(pb + 64'h2080, soc_bus_pkg::ls_w, 64'hf0);
    read_check("enable 1", pb + 64'h2080, soc_bus_pkg::ls_w, 64'hf0);
    bus_write(pb + 64'h2080, soc_bus_pkg::ls_w, 64'h0);
endtask

// low for two edges then high for two
task automatic raise_irq_edge();
    ext_irq = 1'b0;
    next_cycle();
    next_cycle();
    ext_irq = 1'b1;
    next_cycle();
    next_cycle();
endtask

task automatic test_plic_claim();
    soc_bus_pkg::dword_t pb;
    pb = soc_bus_pkg::plic_base;
    read_check("pending", pb + 64'h1000, soc_bus_pkg::ls_w, 64'h0);
    raise_irq_edge();
    check_bit("meip", meip, 1'b0);
    read_check("pending", pb + 64'h1000, soc_bus_pkg::ls_w, 64'h2);
    // machine context
    bus_write(pb + 64'h2000, soc_bus_pkg::ls_w, 64'h2);
    check_bit("meip", meip, 1'b1);
    check_bit("seip", seip, 1'b0);
    read_check("claim 0", pb + 64'h20_0004, soc_bus_pkg::ls_w, 64'h1);
    check_bit("meip", meip, 1'b0);
    read_check("pending", pb + 64'h1000, soc_bus_pkg::ls_w, 64'h0);
    read_check("claim 0 again", pb + 64'h20_0004, soc_bus_pkg::ls_w, 64'h0);
    // supervisor context only
    bus_write(pb + 64'h2000, soc_bus_pkg::ls_w, 64'h0);
    bus_write(pb + 64'h2080, soc_bus_pkg::ls_w, 64'h2);
    raise_irq_edge();
    check_bit("seip", seip, 1'b1);
    check_bit("meip", meip, 1'b0);
    read_check("claim 1", pb + 64'h20_1004, soc_bus_pkg::ls_w, 64'h1);
    check_bit("seip", seip, 1'b0);
    read_check("claim 1 again", pb + 64'h20_1004, soc_bus_pkg::ls_w, 64'h0);
endtask

task automatic test_unmapped();
    // low bits alias the ram word at 0x50 if the upper bits were ignored
    read_check("unmapped read", 64'h4000_0050, soc_bus_pkg::ls_d, 64'h0);
    bus_write(64'h4000_0050, soc_bus_pkg::ls_d, 64'hdead_beef_cafe_f00d);
    // just past the compare register
    bus_write(64'h0200_4008, soc_bus_pkg::ls_d, 64'h1);
    read_check("mtimecmp", soc_bus_pkg::mtimecmp_addr, soc_bus_pkg::ls_d, mtime_value - 64'd5);
    read_check("ram word", 64'h8000_0050, soc_bus_pkg::ls_wu, 64'h1234_7f85);
endtask

`endif

/* verification/tb_soc_bus.sv */
`timescale 1ns/100ps

module tb_soc_bus;

    // 4 ns clock period
    localparam int half_period = 2;
    // inputs move 1 ns after the rising edge
    localparam int drive_delay = 1;
    // accesses issued by the test list below
    localparam int bus_accesses = 57;
    localparam int ns_per_access = 200;
    // external machine time for the timer test
    localparam soc_bus_pkg::dword_t mtime_value = 64'h0000_0123_4567_89ab;

    logic                  CLOCK_50;
    logic                  KEY0;
    soc_bus_pkg::dword_t   address;
    soc_bus_pkg::dword_t   write_data;
    soc_bus_pkg::ls_type_t ls_type;
    logic                  read_en;
    logic                  write_en;
    soc_bus_pkg::dword_t   read_data;
    logic                  read_done;
    logic                  write_done;
    soc_bus_pkg::dword_t   mtime;
    logic                  ext_irq;
    logic                  meip;
    logic                  seip;
    logic                  mtip;

    soc_bus_top UUT (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .address    (address),
        .write_data (write_data),
        .ls_type    (ls_type),
        .read_en    (read_en),
        .write_en   (write_en),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .mtime      (mtime),
        .ext_irq    (ext_irq),
        .meip       (meip),
        .seip       (seip),
        .mtip       (mtip)
    );

    always #half_period CLOCK_50 = ~CLOCK_50;

    `include "tb_soc_bus_tasks.svh"

    // watchdog budget per access plus the reset window
    initial begin
        #(bus_accesses * ns_per_access + 10 * half_period);
        abort_run("timeout: the test list did not finish in time");
    end

    initial begin
        void'($urandom(32'hb86a));
        CLOCK_50   = 1'b0;
        KEY0       = 1'b0;
        address    = '0;
        write_data = '0;
        ls_type    = soc_bus_pkg::ls_w;
        read_en    = 1'b0;
        write_en   = 1'b0;
        mtime      = '0;
        ext_irq    = 1'b0;
        // reset held over three rising edges
        repeat (3) @(posedge CLOCK_50);
        #drive_delay;
        KEY0 = 1'b1;
        test_reset_state();
        test_ram_word();
        test_ram_bytes();
        test_timer();
        test_plic_regs();
        test_plic_claim();
        test_unmapped();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog/soc_bus_top.sv */
`timescale 1ns/100ps

module soc_bus_top (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::dword_t   address,
    input  soc_bus_pkg::dword_t   write_data,
    input  soc_bus_pkg::ls_type_t ls_type,
    input  logic                  read_en,
    input  logic                  write_en,
    output soc_bus_pkg::dword_t   read_data,
    output logic                  read_done,
    output logic                  write_done,
    input  soc_bus_pkg::dword_t   mtime,
    input  logic                  ext_irq,
    output logic                  meip,
    output logic                  seip,
    output logic                  mtip
);

    // sequencer to target handshakes
    logic                  ram_req;
    logic                  ram_ack;
    soc_bus_pkg::dword_t   ram_rdata;
    logic                  plic_req;
    logic                  plic_ack;
    soc_bus_pkg::dword_t   plic_rdata;

    // access held on shared lines during a request
    soc_bus_pkg::dword_t   acc_address;
    soc_bus_pkg::dword_t   acc_wdata;
    soc_bus_pkg::ls_type_t acc_ls_type;
    logic                  acc_write;

    bus_sequencer u_seq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .address     (address),
        .write_data  (write_data),
        .ls_type     (ls_type),
        .read_en     (read_en),
        .write_en    (write_en),
        .read_data   (read_data),
        .read_done   (read_done),
        .write_done  (write_done),
        .mtime       (mtime),
        .mtip        (mtip),
        .ram_req     (ram_req),
        .ram_ack     (ram_ack),
        .ram_rdata   (ram_rdata),
        .plic_req    (plic_req),
        .plic_ack    (plic_ack),
        .plic_rdata  (plic_rdata),
        .acc_address (acc_address),
        .acc_wdata   (acc_wdata),
        .acc_ls_type (acc_ls_type),
        .acc_write   (acc_write)
    );

    word_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (ram_req),
        .ack      (ram_ack),
        .address  (acc_address),
        .wdata    (acc_wdata),
        .ls_type  (acc_ls_type),
        .write    (acc_write),
        .rdata    (ram_rdata)
    );

    plic u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (plic_req),
        .ack      (plic_ack),
        .address  (acc_address),
        .wdata    (acc_wdata),
        .write    (acc_write),
        .rdata    (plic_rdata),
        .ext_irq  (ext_irq),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

/* verilog/bus_sequencer.sv */
`timescale 1ns/100ps

module bus_sequencer (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::dword_t   address,
    input  soc_bus_pkg::dword_t   write_data,
    input  soc_bus_pkg::ls_type_t ls_type,
    input  logic                  read_en,
    input  logic                  write_en,
    output soc_bus_pkg::dword_t   read_data,
    output logic                  read_done,
    output logic                  write_done,
    input  soc_bus_pkg::dword_t   mtime,
    output logic                  mtip,
    output logic                  ram_req,
    input  logic                  ram_ack,
    input  soc_bus_pkg::dword_t   ram_rdata,
    output logic                  plic_req,
    input  logic                  plic_ack,
    input  soc_bus_pkg::dword_t   plic_rdata,
    output soc_bus_pkg::dword_t   acc_address,
    output soc_bus_pkg::dword_t   acc_wdata,
    output soc_bus_pkg::ls_type_t acc_ls_type,
    output logic                  acc_write
);

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_wait
    } state_t;

    state_t              state;
    soc_bus_pkg::dword_t mtimecmp;
    soc_bus_pkg::dword_t local_rdata;
    logic                ram_sel;
    logic                plic_sel;
    logic                mtimecmp_sel;
    logic                mtime_sel;

    // decode on the latched address
    assign ram_sel = (acc_address >= soc_bus_pkg::ram_base) &&
                     (acc_address < soc_bus_pkg::ram_base + 4 * soc_bus_pkg::ram_words);
    // two contexts of threshold/claim close the window
    assign plic_sel = (acc_address >= soc_bus_pkg::plic_base) &&
                      (acc_address < soc_bus_pkg::plic_base + soc_bus_pkg::plic_threshold_off +
                                     2 * soc_bus_pkg::plic_ctx_stride);
    assign mtimecmp_sel = (acc_address == soc_bus_pkg::mtimecmp_addr);
    assign mtime_sel    = (acc_address == soc_bus_pkg::mtime_addr);

    // timer reads, unmapped reads return zero
    assign local_rdata = mtimecmp_sel ? mtimecmp :
                         mtime_sel    ? mtime    : '0;

    // timer interrupt level
    assign mtip = (mtime >= mtimecmp);

    // capture access on the enable pulse
    always_ff @(posedge CLOCK_50) begin
        if (state == s_idle && (read_en || write_en)) begin
            acc_address <= address;
            acc_wdata   <= write_data;
            acc_ls_type <= ls_type;
            acc_write   <= write_en;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= s_idle;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            ram_req    <= 1'b0;
            plic_req   <= 1'b0;
            read_data  <= '0;
            mtimecmp   <= soc_bus_pkg::mtimecmp_reset;
        end else begin
            case (state)
                s_idle: begin
                    if (read_en) begin
                        read_done <= 1'b0;
                        state     <= s_issue;
                    end else if (write_en) begin
                        write_done <= 1'b0;
                        state      <= s_issue;
                    end
                end
                s_issue: begin
                    // new req only once the last ack has dropped
                    if (ram_sel) begin
                        if (!ram_ack) begin
                            ram_req <= 1'b1;
                            state   <= s_wait;
                        end
                    end else if (plic_sel) begin
                        if (!plic_ack) begin
                            plic_req <= 1'b1;
                            state    <= s_wait;
                        end
                    end else begin
                        // timer or unmapped, done here
                        if (!acc_write) begin
                            read_data <= local_rdata;
                        end else if (mtimecmp_sel) begin
                            mtimecmp <= acc_wdata;
                        end
                        read_done  <= 1'b1;
                        write_done <= 1'b1;
                        state      <= s_idle;
                    end
                end
                s_wait: begin
                    if ((ram_req && ram_ack) || (plic_req && plic_ack)) begin
                        if (!acc_write) begin
                            read_data <= ram_req ? ram_rdata : plic_rdata;
                        end
                        // release, target drops ack next
                        ram_req    <= 1'b0;
                        plic_req   <= 1'b0;
                        read_done  <= 1'b1;
                        write_done <= 1'b1;
                        state      <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // master side never opens both directions at once
    no_dual_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(read_en && write_en));

    // a request is held until its target answers
    ram_req_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(ram_req) |-> ram_ack);
    plic_req_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(plic_req) |-> plic_ack);

endmodule

/* verilog/plic.sv */
`timescale 1ns/100ps

module plic (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                req,
    output logic                ack,
    input  soc_bus_pkg::dword_t address,
    input  soc_bus_pkg::dword_t wdata,
    input  logic                write,
    output soc_bus_pkg::dword_t rdata,
    input  logic                ext_irq,
    output logic                meip,
    output logic                seip
);

    soc_bus_pkg::prio_t                   prio [soc_bus_pkg::plic_sources];
    logic [soc_bus_pkg::plic_sources-1:0] pending;
    // per context, index 0 machine and 1 supervisor
    logic [31:0]                          enable [2];
    soc_bus_pkg::prio_t                   threshold [2];
    logic [2:0]                           claim [2];
    logic                                 irq_q;
    soc_bus_pkg::dword_t                  off;
    logic [2:0]                           prio_idx;
    logic                                 prio_sel;
    logic                                 pend_sel;
    logic [1:0]                           en_sel;
    logic [1:0]                           thr_sel;
    logic [1:0]                           clm_sel;

    // offset within the window, 4 bytes per priority
    assign off      = address - soc_bus_pkg::plic_base;
    assign prio_idx = off[4:2];
    assign prio_sel = (off < 4 * soc_bus_pkg::plic_sources);
    assign pend_sel = (off == soc_bus_pkg::plic_pending_off);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_sel[c]  = (off == soc_bus_pkg::plic_enable_off +
                                 c * soc_bus_pkg::plic_ctx_enable_stride);
            thr_sel[c] = (off == soc_bus_pkg::plic_threshold_off +
                                 c * soc_bus_pkg::plic_ctx_stride);
            clm_sel[c] = (off == soc_bus_pkg::plic_claim_off +
                                 c * soc_bus_pkg::plic_ctx_stride);
            // single wired source
            // priority and threshold do not gate it
            claim[c] = (pending[soc_bus_pkg::uart_irq_id] &&
                        enable[c][soc_bus_pkg::uart_irq_id]) ?
                       3'(soc_bus_pkg::uart_irq_id) : 3'd0;
        end
    end

    assign meip = (claim[0] != 3'd0);
    assign seip = (claim[1] != 3'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack     <= 1'b0;
            rdata   <= '0;
            irq_q   <= 1'b0;
            pending <= '0;
            for (int i = 0; i < soc_bus_pkg::plic_sources; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            irq_q <= ext_irq;
            if (!req) begin
                ack <= 1'b0;
            end else if (!ack) begin
                // answer one cycle after req
                ack <= 1'b1;
                if (write) begin
                    // claim writes are ignored
                    if (prio_sel) prio[prio_idx] <= wdata[2:0];
                    for (int c = 0; c < 2; c++) begin
                        if (en_sel[c])  enable[c]    <= wdata[31:0];
                        if (thr_sel[c]) threshold[c] <= wdata[2:0];
                    end
                end else begin
                    rdata <= '0;
                    if (prio_sel) rdata <= soc_bus_pkg::dword_t'(prio[prio_idx]);
                    if (pend_sel) rdata <= soc_bus_pkg::dword_t'(pending);
                    for (int c = 0; c < 2; c++) begin
                        if (en_sel[c])  rdata <= soc_bus_pkg::dword_t'(enable[c]);
                        if (thr_sel[c]) rdata <= soc_bus_pkg::dword_t'(threshold[c]);
                        // claim read clears the named source
                        if (clm_sel[c]) begin
                            rdata <= soc_bus_pkg::dword_t'(claim[c]);
                            pending[claim[c]] <= 1'b0;
                        end
                    end
                end
            end
            // edge capture last so a fresh edge beats a claim
            if (ext_irq && !irq_q) pending[soc_bus_pkg::uart_irq_id] <= 1'b1;
        end
    end

endmodule

/* verilog/word_ram.sv */
`timescale 1ns/100ps

module word_ram (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  req,
    output logic                  ack,
    input  soc_bus_pkg::dword_t   address,
    input  soc_bus_pkg::dword_t   wdata,
    input  soc_bus_pkg::ls_type_t ls_type,
    input  logic                  write,
    output soc_bus_pkg::dword_t   rdata
);

    soc_bus_pkg::word_t     mem [soc_bus_pkg::ram_words];

    // high on the second word step of ld/sd
    logic                   phase;
    logic                   fire;
    logic                   is_dword;
    logic [1:0]             offset;
    soc_bus_pkg::ram_addr_t row;

    // extend a right-aligned word by load type
    function automatic soc_bus_pkg::dword_t load_extend(
        input soc_bus_pkg::word_t    w,
        input soc_bus_pkg::ls_type_t t
    );
        case (t)
            soc_bus_pkg::ls_b:  return {{56{w[7]}}, w[7:0]};
            soc_bus_pkg::ls_h:  return {{48{w[15]}}, w[15:0]};
            soc_bus_pkg::ls_w:  return {{32{w[31]}}, w};
            soc_bus_pkg::ls_bu: return {56'd0, w[7:0]};
            soc_bus_pkg::ls_hu: return {48'd0, w[15:0]};
            soc_bus_pkg::ls_wu: return {32'd0, w};
            default:            return '0;
        endcase
    endfunction

    // one step per cycle while req is open and not yet answered
    assign fire     = req && !ack;
    assign is_dword = (ls_type == soc_bus_pkg::ls_d);
    assign offset   = address[1:0];
    // word index, next index on the high half
    assign row = address[2 +: $bits(soc_bus_pkg::ram_addr_t)] +
                 soc_bus_pkg::ram_addr_t'(phase);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack   <= 1'b0;
            phase <= 1'b0;
        end else if (!req) begin
            // release side of the handshake
            ack <= 1'b0;
        end else if (fire) begin
            if (is_dword && !phase) begin
                phase <= 1'b1;
            end else begin
                phase <= 1'b0;
                ack   <= 1'b1;
            end
        end
    end

    // storage and read path
    always_ff @(posedge CLOCK_50) begin
        if (fire && write) begin
            case (ls_type)
                // only the addressed lanes change
                soc_bus_pkg::ls_b: mem[row][{offset, 3'b000} +: 8]     <= wdata[7:0];
                soc_bus_pkg::ls_h: mem[row][{offset[1], 4'b0000} +: 16] <= wdata[15:0];
                soc_bus_pkg::ls_w: mem[row] <= wdata[31:0];
                // low word first, then high word
                soc_bus_pkg::ls_d: mem[row] <= phase ? wdata[63:32] : wdata[31:0];
                default: ;
            endcase
        end else if (fire) begin
            if (!is_dword) begin
                rdata <= load_extend(mem[row] >> {offset, 3'b000}, ls_type);
            end else if (!phase) begin
                rdata[31:0] <= mem[row];
            end else begin
                rdata[63:32] <= mem[row];
            end
        end
    end

    // ack never leads its request
    ack_needs_req: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(ack) |-> req);

endmodule

/* verilog/soc_bus_pkg.sv */
package soc_bus_pkg;

    // bus data and address width
    localparam int xlen = 64;

    // one ram word and one bus value
    typedef logic [31:0]     word_t;
    typedef logic [xlen-1:0] dword_t;

    // load/store type
    // stores reuse the low four codes for sb sh sw sd
    typedef logic [2:0] ls_type_t;
    localparam ls_type_t ls_b  = 3'b000;
    localparam ls_type_t ls_h  = 3'b001;
    localparam ls_type_t ls_w  = 3'b010;
    localparam ls_type_t ls_d  = 3'b011;
    localparam ls_type_t ls_bu = 3'b100;
    localparam ls_type_t ls_hu = 3'b101;
    localparam ls_type_t ls_wu = 3'b110;

    // on-chip word ram
    localparam dword_t ram_base  = 64'h0000_0000_8000_0000;
    localparam int     ram_words = 2048;
    typedef logic [$clog2(ram_words)-1:0] ram_addr_t;

    // machine timer
    localparam dword_t mtimecmp_addr  = 64'h0000_0000_0200_4000;
    localparam dword_t mtime_addr     = 64'h0000_0000_0200_BFF8;
    localparam dword_t mtimecmp_reset = 64'h0000_0000_8000_0000;

    // interrupt controller window
    localparam dword_t plic_base = 64'h0000_0000_0C00_0000;
    localparam int     plic_sources = 6;
    // offsets below are from plic_base
    localparam dword_t plic_pending_off       = 64'h1000;
    localparam dword_t plic_enable_off        = 64'h2000;
    localparam dword_t plic_ctx_enable_stride = 64'h80;
    localparam dword_t plic_threshold_off     = 64'h20_0000;
    localparam dword_t plic_claim_off         = 64'h20_0004;
    localparam dword_t plic_ctx_stride        = 64'h1000;

    // priority and threshold width
    typedef logic [2:0] prio_t;

    // external line lands on source 1
    localparam int uart_irq_id = 1;

endpackage
